// ==== Makefile ====
TOP := tb_rename_retire

.PHONY: all run lint clean

all: run

# Build and run; pass only when the pass line shows up in the output
run:
	verilator --binary -j 0 --top-module $(TOP) -f build.f -o sim
	@out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

lint:
	verilator --lint-only --timing --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir

// ==== build.f ====
+incdir+tb
verilog/rename_pkg.sv
verilog/reorder_buffer.sv
verilog/map_table.sv
verilog/free_list.sv
verilog/retire_csr.sv
verilog/rename_retire_top.sv
tb/tb_rename_retire.sv

// ==== tb/tb_wb_tasks.svh ====
// Wishbone master tasks and value compare

// Compare one DUT value against the model
task automatic check_eq(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
    if (act_v !== exp_v) begin
        abort_run($sformatf("FAIL %s expected %0d actual %0d", name, exp_v, act_v));
    end
endtask

// Single classic write, held until the registered ack
task automatic wb_write(input logic [5:0] addr, input logic [31:0] data);
    step(MODE_IDLE);
    if (addr == CSR_RETIRED) begin
        retired = 0;                    // Counter clears at the request edge
    end
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b1;
    wb_adr_i = addr;
    wb_dat_i = data;
    do begin
        step(MODE_IDLE);
    end while (wb_ack_o !== 1'b1);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    if (addr == CSR_CTRL && data[0]) begin
        flush_now = 1'b1;               // Pulse lands one cycle after the ack
    end
endtask

// Single classic read
task automatic wb_read(input logic [5:0] addr, output logic [31:0] data);
    step(MODE_IDLE);
    req_occ  = snap_occ;                // What the block samples at the request edge
    req_ret  = snap_ret;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b0;
    wb_adr_i = addr;
    do begin
        step(MODE_IDLE);
    end while (wb_ack_o !== 1'b1);
    data     = wb_dat_o;                // Registered with the ack
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
endtask

// ==== tb/tb_rename_retire.sv ====
// Rename and retire testbench
`timescale 1ns/1ps

module tb_rename_retire;
    import rename_pkg::*;

    localparam int ROB_DEPTH  = 16;
    localparam int PHYS_REGS  = 64;
    localparam int IDX_W      = $clog2(ROB_DEPTH);
    localparam int TAG_W      = $clog2(PHYS_REGS);
    localparam int MAX_CYCLES = 4000;     // Twice the expected run length
    localparam int MODE_IDLE  = 0;        // No dispatch, no completion
    localparam int MODE_RAND  = 1;
    localparam int MODE_DRAIN = 2;        // Complete everything, no dispatch

    logic                            clk_i;
    logic                            rst_n_i;
    logic [DP_WIDTH-1:0]             dp_valid_i;
    arch_reg_t [DP_WIDTH-1:0]        dp_arch_reg_i;
    logic [DP_WIDTH-1:0]             dp_ready_o;
    logic [DP_WIDTH-1:0][TAG_W-1:0]  dp_tag_o;
    logic [DP_WIDTH-1:0][IDX_W-1:0]  dp_rob_idx_o;
    logic [CDB_WIDTH-1:0]            cdb_valid_i;
    logic [CDB_WIDTH-1:0][IDX_W-1:0] cdb_rob_idx_i;
    logic [RT_WIDTH-1:0]             retire_valid_o;
    arch_reg_t [RT_WIDTH-1:0]        retire_arch_reg_o;
    logic [RT_WIDTH-1:0][TAG_W-1:0]  retire_tag_o;
    logic                            wb_cyc_i;
    logic                            wb_stb_i;
    logic                            wb_we_i;
    logic [7:2]                      wb_adr_i;
    logic [31:0]                     wb_dat_i;
    logic [31:0]                     wb_dat_o;
    logic                            wb_ack_o;

    //////////////////////////////
    // Reference model state
    //////////////////////////////
    logic [31:0] lcg_state;
    int          cycle_cnt = 0;
    int          m_spec [ARCH_REGS];    // Speculative map
    int          m_arch [ARCH_REGS];    // Architectural map
    int          m_fl   [PHYS_REGS];    // Free list ring
    int          fl_spec;
    int          fl_ret;
    int          fl_tail;
    int          e_reg  [ROB_DEPTH];    // ROB entries by index
    int          e_tag  [ROB_DEPTH];
    int          e_old  [ROB_DEPTH];
    bit          e_done [ROB_DEPTH];
    int          r_head;
    int          r_cnt;                 // Entries in flight
    int          retired;
    bit          flush_now;             // flush_o high this cycle
    int          snap_occ;              // Model before the coming edge
    int          snap_ret;
    int          req_occ;               // Seen by the last read request
    int          req_ret;
    logic [31:0] rdata;

    rename_retire_top #(.ROB_DEPTH(ROB_DEPTH), .PHYS_REGS(PHYS_REGS)) dut (.*);

    function automatic int next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[30:16]);  // Upper bits, low ones repeat fast
    endfunction

    // Two slot thermometer
    function automatic int thermo(input int n);
        return (n >= 2) ? 3 : ((n == 1) ? 1 : 0);
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "Run stopped at first error");
    endtask

    `include "tb_wb_tasks.svh"

    //////////////////////////////
    // One cycle: check, drive, advance model
    //////////////////////////////
    task automatic step(input int mode);
        int nrt;
        int nfire;
        int ncdb;
        int tail;
        int idx;
        int pick;
        int pend [$];
        @(negedge clk_i);
        snap_occ = r_cnt;
        snap_ret = retired;
        tail     = (r_head + r_cnt) % ROB_DEPTH;
        check_eq("dp_ready", thermo(ROB_DEPTH - r_cnt), 32'(dp_ready_o));
        nrt = 0;                          // Completed prefix of the head
        while (!flush_now && nrt < RT_WIDTH && nrt < r_cnt
               && e_done[(r_head + nrt) % ROB_DEPTH]) begin
            nrt++;
        end
        check_eq("retire_valid", thermo(nrt), 32'(retire_valid_o));
        for (int i = 0; i < nrt; i++) begin
            idx = (r_head + i) % ROB_DEPTH;
            check_eq("retire_arch_reg", e_reg[idx], 32'(retire_arch_reg_o[i]));
            check_eq("retire_tag", e_tag[idx], 32'(retire_tag_o[i]));
        end
        dp_valid_i  = '0;
        cdb_valid_i = '0;
        if (mode == MODE_RAND) begin
            dp_valid_i = DP_WIDTH'(thermo(next_rand() % 3));
            for (int i = 0; i < DP_WIDTH; i++) begin
                dp_arch_reg_i[i] = arch_reg_t'(next_rand());
            end
        end
        nfire = 0;                        // Flush cycle accepts nothing
        if (!flush_now) begin
            nfire = $countones(dp_valid_i & DP_WIDTH'(thermo(ROB_DEPTH - r_cnt)));
        end
        for (int i = 0; i < nfire; i++) begin
            check_eq("dp_tag", m_fl[(fl_spec + i) % PHYS_REGS], 32'(dp_tag_o[i]));
            check_eq("dp_rob_idx", (tail + i) % ROB_DEPTH, 32'(dp_rob_idx_o[i]));
        end
        if (mode != MODE_IDLE) begin
            for (int i = 0; i < r_cnt; i++) begin
                if (!e_done[(r_head + i) % ROB_DEPTH]) begin
                    pend.push_back((r_head + i) % ROB_DEPTH);
                end
            end
            ncdb = (mode == MODE_DRAIN) ? 2 : next_rand() % 4 - 1;  // Mostly slow completion
            for (int c = 0; c < ncdb && pend.size() > 0; c++) begin
                pick             = next_rand() % pend.size();
                cdb_valid_i[c]   = 1'b1;
                cdb_rob_idx_i[c] = IDX_W'(pend[pick]);
                e_done[pend[pick]] = 1'b1;
                pend.delete(pick);        // Keep the two slots distinct
            end
        end
        // Retire side of the edge
        for (int i = 0; i < nrt; i++) begin
            idx                = (r_head + i) % ROB_DEPTH;
            m_arch[e_reg[idx]] = e_tag[idx];
            m_fl[fl_tail]      = e_old[idx];
            fl_tail            = (fl_tail + 1) % PHYS_REGS;
        end
        fl_ret  = (fl_ret + nrt) % PHYS_REGS;
        r_head  = (r_head + nrt) % ROB_DEPTH;
        r_cnt   = r_cnt - nrt;
        retired = retired + nrt;
        // Dispatch side, in slot order so slot 1 sees slot 0
        for (int i = 0; i < nfire; i++) begin
            idx                = (tail + i) % ROB_DEPTH;
            e_reg[idx]         = int'(dp_arch_reg_i[i]);
            e_tag[idx]         = m_fl[(fl_spec + i) % PHYS_REGS];
            e_old[idx]         = m_spec[e_reg[idx]];
            e_done[idx]        = 1'b0;
            m_spec[e_reg[idx]] = e_tag[idx];
        end
        fl_spec = (fl_spec + nfire) % PHYS_REGS;
        r_cnt   = r_cnt + nfire;
        if (flush_now) begin
            r_head    = 0;                // Buffer restarts at entry 0
            r_cnt     = 0;
            m_spec    = m_arch;
            fl_spec   = fl_ret;
            flush_now = 1'b0;
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            abort_run($sformatf("Timeout, run did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    initial begin
        lcg_state     = 32'h28a5cddd;
        rst_n_i       = 1'b0;
        dp_valid_i    = '0;
        dp_arch_reg_i = '0;
        cdb_valid_i   = '0;
        cdb_rob_idx_i = '0;
        wb_cyc_i      = 1'b0;
        wb_stb_i      = 1'b0;
        wb_we_i       = 1'b0;
        wb_adr_i      = '0;
        wb_dat_i      = '0;
        flush_now     = 1'b0;
        retired       = 0;
        r_head        = 0;
        r_cnt         = 0;
        fl_spec       = 0;
        fl_ret        = 0;
        fl_tail       = PHYS_REGS - ARCH_REGS;
        for (int i = 0; i < ARCH_REGS; i++) begin
            m_spec[i] = i;                // Identity map
            m_arch[i] = i;
        end
        for (int i = 0; i < PHYS_REGS; i++) begin
            m_fl[i] = (i + ARCH_REGS) % PHYS_REGS;
        end
        repeat (4) @(posedge clk_i);      // Four rising edges in reset
        @(negedge clk_i);
        rst_n_i = 1'b1;
        check_eq("wb_ack after reset", 0, 32'(wb_ack_o));

        repeat (800) step(MODE_RAND);
        wb_read(CSR_RETIRED, rdata);      // Counter while traffic runs
        check_eq("retired busy", req_ret, rdata);
        wb_read(CSR_STATUS, rdata);       // Occupancy with entries in flight
        check_eq("status busy", req_occ, rdata);

        // Flush, then precise state readback
        wb_write(CSR_CTRL, 32'h1);
        step(MODE_RAND);                  // Traffic in the flush cycle is dropped
        wb_read(CSR_STATUS, rdata);
        check_eq("status after flush", 0, rdata);
        for (int n = 0; n < ARCH_REGS; n++) begin
            wb_read(CSR_MAP_BASE + 6'(n), rdata);
            check_eq("arch map", m_arch[n], rdata);
        end
        wb_read(CSR_RETIRED, rdata);
        check_eq("retired after flush", retired, rdata);
        wb_write(CSR_RETIRED, 32'h0);
        wb_read(CSR_RETIRED, rdata);
        check_eq("retired cleared", 0, rdata);

        // Dispatch resumes from the restored free list
        repeat (800) step(MODE_RAND);
        while (r_cnt > 0) begin
            step(MODE_DRAIN);
        end
        wb_read(CSR_RETIRED, rdata);
        check_eq("retired final", req_ret, rdata);
        wb_read(CSR_STATUS, rdata);
        check_eq("status drained", req_occ, rdata);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== verilog/free_list.sv ====
// Physical tag free list
`timescale 1ns/1ps

module free_list #(
    parameter  int PHYS_REGS = 64,
    localparam int TAG_W     = $clog2(PHYS_REGS)
) (
    input  logic                                        clk_i,
    input  logic                                        rst_n_i,
    input  logic                                        flush_i,
    input  logic [rename_pkg::DP_WIDTH-1:0]             dp_fire_i,
    input  logic [rename_pkg::RT_WIDTH-1:0]             retire_valid_i,
    input  logic [rename_pkg::RT_WIDTH-1:0][TAG_W-1:0]  retire_tag_old_i,
    output logic [rename_pkg::DP_WIDTH-1:0][TAG_W-1:0]  free_tag_o
);
    import rename_pkg::*;

    // Queue as deep as the tag space so it can never overflow
    logic [TAG_W-1:0] fq [PHYS_REGS];

    //////////////////////////////
    // Queue pointers
    //////////////////////////////
    logic [TAG_W-1:0] spec_head;     // Next tag handed to dispatch
    logic [TAG_W-1:0] ret_head;      // Oldest tag still owned by in flight work
    logic [TAG_W-1:0] tail;          // Append point for released tags
    logic [TAG_W-1:0] ret_head_nxt;
    logic [TAG_W-1:0] dp_cnt;
    logic [TAG_W-1:0] rt_cnt;

    always_comb begin
        for (int i = 0; i < DP_WIDTH; i++) begin
            free_tag_o[i] = fq[spec_head + TAG_W'(i)];
        end
    end

    always_comb begin
        dp_cnt = '0;
        rt_cnt = '0;
        for (int i = 0; i < DP_WIDTH; i++) begin
            dp_cnt = dp_cnt + TAG_W'(dp_fire_i[i]);
        end
        for (int i = 0; i < RT_WIDTH; i++) begin
            rt_cnt = rt_cnt + TAG_W'(retire_valid_i[i]);
        end
    end

    // Retired slots consume tags in dispatch order
    assign ret_head_nxt = ret_head + rt_cnt;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < PHYS_REGS; i++) begin
                fq[i] <= TAG_W'(i + ARCH_REGS);    // Tags above the identity map
            end
            spec_head <= '0;
            ret_head  <= '0;
            tail      <= TAG_W'(PHYS_REGS - ARCH_REGS);
        end else begin
            ret_head <= ret_head_nxt;
            tail     <= tail + rt_cnt;
            if (flush_i) begin
                spec_head <= ret_head_nxt;     // Discarded tags become free again
            end else begin
                spec_head <= spec_head + dp_cnt;
            end
            // Old tags go back in retire order
            for (int i = 0; i < RT_WIDTH; i++) begin
                if (retire_valid_i[i]) begin
                    fq[tail + TAG_W'(i)] <= retire_tag_old_i[i];
                end
            end
        end
    end

endmodule

// ==== verilog/map_table.sv ====
// Speculative and architectural map table
`timescale 1ns/1ps

module map_table #(
    parameter  int PHYS_REGS = 64,
    localparam int TAG_W     = $clog2(PHYS_REGS)
) (
    input  logic                                              clk_i,
    input  logic                                              rst_n_i,
    input  logic                                              flush_i,
    input  logic [rename_pkg::DP_WIDTH-1:0]                   dp_fire_i,
    input  rename_pkg::arch_reg_t [rename_pkg::DP_WIDTH-1:0]  dp_arch_reg_i,
    input  logic [rename_pkg::DP_WIDTH-1:0][TAG_W-1:0]        dp_tag_i,
    output logic [rename_pkg::DP_WIDTH-1:0][TAG_W-1:0]        dp_tag_old_o,
    input  logic [rename_pkg::RT_WIDTH-1:0]                   retire_valid_i,
    input  rename_pkg::arch_reg_t [rename_pkg::RT_WIDTH-1:0]  retire_arch_reg_i,
    input  logic [rename_pkg::RT_WIDTH-1:0][TAG_W-1:0]        retire_tag_i,
    input  rename_pkg::arch_reg_t                             rd_arch_reg_i,
    output logic [TAG_W-1:0]                                  rd_tag_o
);
    import rename_pkg::*;

    logic [TAG_W-1:0] spec_map [ARCH_REGS];   // Front end view
    logic [TAG_W-1:0] arch_map [ARCH_REGS];   // Precise state

    // Old tag lookup, later slots see earlier slots of the same group
    always_comb begin
        for (int i = 0; i < DP_WIDTH; i++) begin
            dp_tag_old_o[i] = spec_map[dp_arch_reg_i[i]];
            for (int j = 0; j < i; j++) begin
                if (dp_arch_reg_i[j] == dp_arch_reg_i[i]) begin
                    dp_tag_old_o[i] = dp_tag_i[j];   // Bypass from older slot
                end
            end
        end
    end

    assign rd_tag_o = arch_map[rd_arch_reg_i];  // Readback port for CSR window

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                spec_map[i] <= TAG_W'(i);          // Identity map out of reset
                arch_map[i] <= TAG_W'(i);
            end
        end else begin
            if (flush_i) begin
                spec_map <= arch_map;              // Recover precise state
            end else begin
                for (int i = 0; i < DP_WIDTH; i++) begin
                    if (dp_fire_i[i]) begin
                        spec_map[dp_arch_reg_i[i]] <= dp_tag_i[i];  // Younger slot wins
                    end
                end
            end
            for (int i = 0; i < RT_WIDTH; i++) begin
                if (retire_valid_i[i]) begin
                    arch_map[retire_arch_reg_i[i]] <= retire_tag_i[i];
                end
            end
        end
    end

endmodule

// ==== verilog/rename_pkg.sv ====
// Rename and retire shared definitions
package rename_pkg;

    //////////////////////////////
    // Machine widths
    //////////////////////////////
    localparam int ARCH_REGS = 32;  // Architectural registers
    localparam int DP_WIDTH  = 2;   // Dispatch slots per cycle
    localparam int RT_WIDTH  = 2;   // Retire slots per cycle
    localparam int CDB_WIDTH = 2;   // Completion bus slots

    // Architectural register index
    typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t;

    //////////////////////////////
    // Register block word addresses
    //////////////////////////////
    localparam logic [5:0] CSR_CTRL     = 6'd0;   // Bit 0 requests a flush
    localparam logic [5:0] CSR_STATUS   = 6'd1;   // Occupancy
    localparam logic [5:0] CSR_RETIRED  = 6'd2;   // Retire counter, write clears
    localparam logic [5:0] CSR_MAP_BASE = 6'd32;  // Architectural map window

endpackage

// ==== verilog/rename_retire_top.sv ====
// Rename and retire top level
`timescale 1ns/1ps

module rename_retire_top #(
    parameter  int ROB_DEPTH = 16,
    parameter  int PHYS_REGS = 64,
    localparam int IDX_W     = $clog2(ROB_DEPTH),
    localparam int TAG_W     = $clog2(PHYS_REGS)
) (
    input  logic                                              clk_i,
    input  logic                                              rst_n_i,
    // Dispatch
    input  logic [rename_pkg::DP_WIDTH-1:0]                   dp_valid_i,
    input  rename_pkg::arch_reg_t [rename_pkg::DP_WIDTH-1:0]  dp_arch_reg_i,
    output logic [rename_pkg::DP_WIDTH-1:0]                   dp_ready_o,
    output logic [rename_pkg::DP_WIDTH-1:0][TAG_W-1:0]        dp_tag_o,
    output logic [rename_pkg::DP_WIDTH-1:0][IDX_W-1:0]        dp_rob_idx_o,
    // Completion
    input  logic [rename_pkg::CDB_WIDTH-1:0]                  cdb_valid_i,
    input  logic [rename_pkg::CDB_WIDTH-1:0][IDX_W-1:0]       cdb_rob_idx_i,
    // Retire
    output logic [rename_pkg::RT_WIDTH-1:0]                   retire_valid_o,
    output rename_pkg::arch_reg_t [rename_pkg::RT_WIDTH-1:0]  retire_arch_reg_o,
    output logic [rename_pkg::RT_WIDTH-1:0][TAG_W-1:0]        retire_tag_o,
    // Wishbone
    input  logic                                              wb_cyc_i,
    input  logic                                              wb_stb_i,
    input  logic                                              wb_we_i,
    input  logic [7:2]                                        wb_adr_i,
    input  logic [31:0]                                       wb_dat_i,
    output logic [31:0]                                       wb_dat_o,
    output logic                                              wb_ack_o
);
    import rename_pkg::*;

    wire [DP_WIDTH-1:0]            dp_fire = dp_valid_i & dp_ready_o;  // Accepted slots
    wire [DP_WIDTH-1:0][TAG_W-1:0] dp_tag_old;
    wire [RT_WIDTH-1:0][TAG_W-1:0] retire_tag_old;
    wire [IDX_W:0]                 occupancy;
    wire                           flush;
    wire arch_reg_t                rd_arch_reg;
    wire [TAG_W-1:0]               rd_tag;

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH), .PHYS_REGS(PHYS_REGS)) u_rob (
        .clk_i, .rst_n_i, .flush_i(flush),
        .dp_valid_i, .dp_arch_reg_i, .dp_tag_i(dp_tag_o), .dp_tag_old_i(dp_tag_old),
        .dp_ready_o, .dp_rob_idx_o,
        .cdb_valid_i, .cdb_rob_idx_i,
        .retire_valid_o, .retire_arch_reg_o, .retire_tag_o,
        .retire_tag_old_o(retire_tag_old), .occupancy_o(occupancy)
    );

    map_table #(.PHYS_REGS(PHYS_REGS)) u_map (
        .clk_i, .rst_n_i, .flush_i(flush),
        .dp_fire_i(dp_fire), .dp_arch_reg_i, .dp_tag_i(dp_tag_o), .dp_tag_old_o(dp_tag_old),
        .retire_valid_i(retire_valid_o), .retire_arch_reg_i(retire_arch_reg_o),
        .retire_tag_i(retire_tag_o),
        .rd_arch_reg_i(rd_arch_reg), .rd_tag_o(rd_tag)
    );

    free_list #(.PHYS_REGS(PHYS_REGS)) u_fl (
        .clk_i, .rst_n_i, .flush_i(flush),
        .dp_fire_i(dp_fire),
        .retire_valid_i(retire_valid_o), .retire_tag_old_i(retire_tag_old),
        .free_tag_o(dp_tag_o)
    );

    retire_csr #(.ROB_DEPTH(ROB_DEPTH), .PHYS_REGS(PHYS_REGS)) u_csr (
        .clk_i, .rst_n_i,
        .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
        .retire_valid_i(retire_valid_o), .occupancy_i(occupancy), .rd_tag_i(rd_tag),
        .flush_o(flush), .rd_arch_reg_o(rd_arch_reg)
    );

endmodule

// ==== verilog/reorder_buffer.sv ====
// Reorder buffer
`timescale 1ns/1ps

module reorder_buffer #(
    parameter  int ROB_DEPTH = 16,
    parameter  int PHYS_REGS = 64,
    localparam int IDX_W     = $clog2(ROB_DEPTH),
    localparam int TAG_W     = $clog2(PHYS_REGS)
) (
    input  logic                                               clk_i,
    input  logic                                               rst_n_i,
    input  logic                                               flush_i,
    // Dispatch side
    input  logic [rename_pkg::DP_WIDTH-1:0]                    dp_valid_i,
    input  rename_pkg::arch_reg_t [rename_pkg::DP_WIDTH-1:0]   dp_arch_reg_i,
    input  logic [rename_pkg::DP_WIDTH-1:0][TAG_W-1:0]         dp_tag_i,
    input  logic [rename_pkg::DP_WIDTH-1:0][TAG_W-1:0]         dp_tag_old_i,
    output logic [rename_pkg::DP_WIDTH-1:0]                    dp_ready_o,
    output logic [rename_pkg::DP_WIDTH-1:0][IDX_W-1:0]         dp_rob_idx_o,
    // Completion bus
    input  logic [rename_pkg::CDB_WIDTH-1:0]                   cdb_valid_i,
    input  logic [rename_pkg::CDB_WIDTH-1:0][IDX_W-1:0]        cdb_rob_idx_i,
    // Retire side
    output logic [rename_pkg::RT_WIDTH-1:0]                    retire_valid_o,
    output rename_pkg::arch_reg_t [rename_pkg::RT_WIDTH-1:0]   retire_arch_reg_o,
    output logic [rename_pkg::RT_WIDTH-1:0][TAG_W-1:0]         retire_tag_o,
    output logic [rename_pkg::RT_WIDTH-1:0][TAG_W-1:0]         retire_tag_old_o,
    output logic [IDX_W:0]                                     occupancy_o
);
    import rename_pkg::*;

    // Entry payload
    arch_reg_t        ent_arch_reg [ROB_DEPTH];
    logic [TAG_W-1:0] ent_tag      [ROB_DEPTH];
    logic [TAG_W-1:0] ent_tag_old  [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] complete;      // One bit per entry

    // Pointers with wrap bit on top
    logic [IDX_W:0] head;
    logic [IDX_W:0] tail;
    logic [IDX_W:0] free_cnt;
    logic [IDX_W:0] dp_cnt;
    logic [IDX_W:0] rt_cnt;
    logic [DP_WIDTH-1:0] dp_fire;

    //////////////////////////////
    // Occupancy and ready
    //////////////////////////////
    assign occupancy_o = tail - head;   // Wrap bit keeps full apart from empty
    assign free_cnt    = (IDX_W+1)'(ROB_DEPTH) - occupancy_o;

    always_comb begin
        for (int i = 0; i < DP_WIDTH; i++) begin
            dp_ready_o[i]   = free_cnt > (IDX_W+1)'(i);  // Thermometer of free entries
            dp_rob_idx_o[i] = tail[IDX_W-1:0] + IDX_W'(i);
        end
    end

    // Accepted slots, nothing taken during flush
    assign dp_fire = dp_valid_i & dp_ready_o & {DP_WIDTH{~flush_i}};

    //////////////////////////////
    // Retire chain
    //////////////////////////////
    always_comb begin : retire_chain
        logic             chain;
        logic [IDX_W-1:0] idx;
        chain = ~flush_i;                   // Flushed entries never retire
        for (int i = 0; i < RT_WIDTH; i++) begin
            idx = head[IDX_W-1:0] + IDX_W'(i);
            // Stop at the first incomplete or empty slot
            chain = chain & (occupancy_o > (IDX_W+1)'(i)) & complete[idx];
            retire_valid_o[i]    = chain;
            retire_arch_reg_o[i] = ent_arch_reg[idx];
            retire_tag_o[i]      = ent_tag[idx];
            retire_tag_old_o[i]  = ent_tag_old[idx];
        end
    end

    // Pointer advance amounts
    always_comb begin
        dp_cnt = '0;
        rt_cnt = '0;
        for (int i = 0; i < DP_WIDTH; i++) begin
            dp_cnt = dp_cnt + (IDX_W+1)'(dp_fire[i]);
        end
        for (int i = 0; i < RT_WIDTH; i++) begin
            rt_cnt = rt_cnt + (IDX_W+1)'(retire_valid_o[i]);
        end
    end

    //////////////////////////////
    // Pointers and completion bits
    //////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head     <= '0;
            tail     <= '0;
            complete <= '0;
        end else if (flush_i) begin
            head     <= '0;                 // Empty buffer, restart at entry 0
            tail     <= '0;
            complete <= '0;
        end else begin
            head <= head + rt_cnt;
            tail <= tail + dp_cnt;
            for (int i = 0; i < DP_WIDTH; i++) begin
                if (dp_fire[i]) begin
                    complete[dp_rob_idx_o[i]] <= 1'b0;   // New entry waits for CDB
                end
            end
            for (int i = 0; i < CDB_WIDTH; i++) begin
                if (cdb_valid_i[i]) begin
                    complete[cdb_rob_idx_i[i]] <= 1'b1;  // Out of order completion
                end
            end
        end
    end

    // Payload written at dispatch
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < DP_WIDTH; i++) begin
            if (dp_fire[i]) begin
                ent_arch_reg[dp_rob_idx_o[i]] <= dp_arch_reg_i[i];
                ent_tag[dp_rob_idx_o[i]]      <= dp_tag_i[i];
                ent_tag_old[dp_rob_idx_o[i]]  <= dp_tag_old_i[i];
            end
        end
    end

endmodule

// ==== verilog/retire_csr.sv ====
// Retire control register block
`timescale 1ns/1ps

module retire_csr #(
    parameter  int ROB_DEPTH = 16,
    parameter  int PHYS_REGS = 64,
    localparam int OCC_W     = $clog2(ROB_DEPTH) + 1,
    localparam int TAG_W     = $clog2(PHYS_REGS)
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    // Wishbone classic slave
    input  logic                                wb_cyc_i,
    input  logic                                wb_stb_i,
    input  logic                                wb_we_i,
    input  logic [7:2]                          wb_adr_i,
    input  logic [31:0]                         wb_dat_i,
    output logic [31:0]                         wb_dat_o,
    output logic                                wb_ack_o,
    // Core side
    input  logic [rename_pkg::RT_WIDTH-1:0]     retire_valid_i,
    input  logic [OCC_W-1:0]                    occupancy_i,
    input  logic [TAG_W-1:0]                    rd_tag_i,
    output logic                                flush_o,
    output rename_pkg::arch_reg_t               rd_arch_reg_o
);
    import rename_pkg::*;

    logic        req;              // New access this cycle
    logic        flush_arm;        // High during the flush write ack
    logic [31:0] retired_cnt;
    logic [31:0] rt_sum;
    logic [31:0] rd_mux;

    assign req           = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    assign rd_arch_reg_o = arch_reg_t'(wb_adr_i[6:2]);   // Window offset

    //////////////////////////////
    // Read decode
    //////////////////////////////
    always_comb begin
        rt_sum = '0;
        for (int i = 0; i < RT_WIDTH; i++) begin
            rt_sum = rt_sum + 32'(retire_valid_i[i]);
        end
        if (wb_adr_i == CSR_STATUS) begin
            rd_mux = 32'(occupancy_i);
        end else if (wb_adr_i == CSR_RETIRED) begin
            rd_mux = retired_cnt;
        end else if (wb_adr_i[7]) begin   // Upper half is the map window
            rd_mux = 32'(rd_tag_i);
        end else begin
            rd_mux = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_ack_o    <= 1'b0;
            flush_arm   <= 1'b0;
            flush_o     <= 1'b0;
            retired_cnt <= '0;
        end else begin
            wb_ack_o  <= req;                              // Single cycle ack
            flush_arm <= req & wb_we_i & (wb_adr_i == CSR_CTRL) & wb_dat_i[0];
            flush_o   <= flush_arm;                        // Cycle after the ack
            if (req && wb_we_i && wb_adr_i == CSR_RETIRED) begin
                retired_cnt <= '0;
            end else begin
                retired_cnt <= retired_cnt + rt_sum;
            end
        end
    end

    // Read data captured with the ack
    always_ff @(posedge clk_i) begin
        if (req) begin
            wb_dat_o <= rd_mux;
        end
    end

endmodule
